// File: rtl/prof_pkg.sv
// trace, instruction and call tracker definitions shared by the profiler blocks
package prof_pkg;

	// program counter and counter widths
	localparam int ADDR_W = 32;
	localparam int CW = 32;

	// function table and call stack sizes, slot 0 stands for unlisted code
	localparam int FUNC_COUNT = 8;
	localparam int FUNC_IDX_W = 3;
	localparam int STACK_DEPTH = 8;

	// MIPS encodings the tracker looks for
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] FUNCT_JR = 6'h08;
	localparam logic [4:0] REG_RA = 5'd31;

	// register format, used for jr
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_view_s;

	// jump format, used for jal
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_view_s;

	typedef union packed {
		r_view_s r_view;
		j_view_s j_view;
	} mips_instr_u;

	// one cycle of the core trace
	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		mips_instr_u       instr;
		logic              valid;
	} trace_s;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2
	} tracker_state_e;

endpackage

// File: rtl/leap_bus_pkg.sv
// memory-mapped slave request format and register map of the profiler
package leap_bus_pkg;

	localparam int BUS_ADDR_W = 8;

	// control: bit 0 soft reset, bit 1 arm
	localparam logic [BUS_ADDR_W-1:0] REG_CTRL = 8'h00;
	// status: state [1:0], overflow [2], depth [6:3]
	localparam logic [BUS_ADDR_W-1:0] REG_STATUS = 8'h01;
	// eight function start addresses
	localparam logic [BUS_ADDR_W-1:0] REG_FUNC_BASE = 8'h10;
	// eight cycle counters, read only
	localparam logic [BUS_ADDR_W-1:0] REG_COUNT_BASE = 8'h20;

	// one host access, read data follows one cycle later
	typedef struct packed {
		logic                  chipselect;
		logic                  read;
		logic                  write;
		logic [BUS_ADDR_W-1:0] address;
		logic [31:0]           writedata;
	} bus_req_s;

endpackage

// File: rtl/trace_align.sv
// realigns the fetch-side core trace to the execute stage for the call tracker
`timescale 1ns/1ps

module trace_align (
	input  logic             clk,
	input  logic             reset,
	input  prof_pkg::trace_s trace_in,
	output prof_pkg::trace_s aligned,
	output logic             advance
);

	logic [prof_pkg::ADDR_W-1:0] pc_r;
	logic [prof_pkg::ADDR_W-1:0] pc_rr;
	logic [prof_pkg::ADDR_W-1:0] pc_rrr;
	prof_pkg::mips_instr_u       ins_r;
	prof_pkg::mips_instr_u       ins_rr;
	logic                        valid_r;
	logic                        valid_rr;
	logic                        pc_change;

	// the core holds pc during stalls, so only a new pc moves the pipe
	assign pc_change = (pc_r != trace_in.pc);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_r     <= '0;
			pc_rr    <= '0;
			pc_rrr   <= '0;
			ins_r    <= '0;
			ins_rr   <= '0;
			valid_r  <= 1'b0;
			valid_rr <= 1'b0;
			advance  <= 1'b0;
		end else begin
			pc_r    <= trace_in.pc;
			advance <= pc_change;
			// instruction is one stage shorter than pc so the pair matches
			if (pc_change) begin
				ins_r    <= trace_in.instr;
				ins_rr   <= ins_r;
				valid_r  <= trace_in.valid;
				valid_rr <= valid_r;
				pc_rr    <= pc_r;
				pc_rrr   <= pc_rr;
			end
		end
	end

	assign aligned = '{pc: pc_rrr, instr: ins_rr, valid: valid_rr};

endmodule

// File: rtl/func_lookup.sv
// function start-address table written by software, maps a call target to its index
`timescale 1ns/1ps

module func_lookup (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            tbl_we,
	input  logic [prof_pkg::FUNC_IDX_W-1:0] tbl_idx,
	input  logic [prof_pkg::ADDR_W-1:0]     tbl_addr,
	input  logic [prof_pkg::ADDR_W-1:0]     target,
	output logic [prof_pkg::ADDR_W-1:0]     entry_addr,
	output logic [prof_pkg::FUNC_IDX_W-1:0] func_idx,
	input  logic [prof_pkg::FUNC_IDX_W-1:0] tbl_rd_idx,
	output logic [prof_pkg::ADDR_W-1:0]     tbl_rd_addr
);

	logic [prof_pkg::ADDR_W-1:0]     tbl [prof_pkg::FUNC_COUNT];
	logic [prof_pkg::FUNC_IDX_W-1:0] match_idx;

	// only the hard reset clears the table, a soft reset keeps it
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < prof_pkg::FUNC_COUNT; i++) begin
				tbl[i] <= '0;
			end
		end else if (tbl_we) begin
			tbl[tbl_idx] <= tbl_addr;
		end
	end

	// parallel compare, lowest listed slot wins
	// slot 0 is never matched, it collects unlisted callees
	always_comb begin
		match_idx = '0;
		for (int i = prof_pkg::FUNC_COUNT - 1; i > 0; i--) begin
			if (tbl[i] == target) begin
				match_idx = prof_pkg::FUNC_IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			func_idx <= '0;
		end else begin
			func_idx <= match_idx;
		end
	end

	// slot 1 holds the entry function
	assign entry_addr = tbl[1];
	assign tbl_rd_addr = tbl[tbl_rd_idx];

endmodule

// File: rtl/call_tracker.sv
// FSM that finds run start, calls, returns and run end and keeps the call stack
`timescale 1ns/1ps

module call_tracker (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            arm,
	input  prof_pkg::trace_s                aligned,
	input  logic                            advance,
	input  logic [prof_pkg::ADDR_W-1:0]     entry_addr,
	input  logic [prof_pkg::FUNC_IDX_W-1:0] func_idx,
	output logic [prof_pkg::ADDR_W-1:0]     lookup_target,
	output logic [prof_pkg::FUNC_IDX_W-1:0] cur_func,
	output logic                            count_en,
	output logic                            exe_start,
	output logic                            exe_end,
	output prof_pkg::tracker_state_e        state,
	output logic                            overflow,
	output logic [3:0]                      depth
);

	logic [prof_pkg::FUNC_IDX_W-1:0] stack [prof_pkg::STACK_DEPTH];
	logic [3:0]                      ptr;
	logic [3:0]                      ptr_m1;
	logic [3:0]                      excess;
	logic                            pend;
	logic                            is_jal;
	logic                            is_ret;
	logic [prof_pkg::FUNC_IDX_W-1:0] push_val;

	// jal decoded through the jump view, jr $ra through the register view
	assign is_jal = aligned.valid && (aligned.instr.j_view.opcode == prof_pkg::OP_JAL);
	assign is_ret = (aligned.instr.r_view.opcode == 6'd0) &&
		(aligned.instr.r_view.funct == prof_pkg::FUNCT_JR) &&
		(aligned.instr.r_view.rs == prof_pkg::REG_RA);

	// jump target keeps the upper pc bits, func_lookup registers the result
	assign lookup_target = {aligned.pc[prof_pkg::ADDR_W-1:prof_pkg::ADDR_W-4],
		aligned.instr.j_view.target, 2'b00};

	// a lookup still in flight is the function that the stack must see
	assign push_val = pend ? func_idx : cur_func;
	assign ptr_m1 = ptr - 4'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= prof_pkg::IDLE;
			cur_func  <= '0;
			ptr       <= '0;
			excess    <= '0;
			overflow  <= 1'b0;
			pend      <= 1'b0;
			exe_start <= 1'b0;
			exe_end   <= 1'b0;
			for (int i = 0; i < prof_pkg::STACK_DEPTH; i++) begin
				stack[i] <= '0;
			end
		end else begin
			exe_start <= 1'b0;
			exe_end   <= 1'b0;
			pend      <= 1'b0;
			if (pend) begin
				cur_func <= func_idx;
			end
			case (state)
				prof_pkg::IDLE: begin
					if (arm && advance && (aligned.pc == entry_addr)) begin
						state     <= prof_pkg::RUN;
						cur_func  <= prof_pkg::FUNC_IDX_W'(1);
						exe_start <= 1'b1;
					end
				end
				prof_pkg::RUN: begin
					if (advance && is_jal) begin
						if (ptr == prof_pkg::STACK_DEPTH) begin
							// stack full, stay in the current function and remember the call
							overflow <= 1'b1;
							if (excess != '1) begin
								excess <= excess + 4'd1;
							end
						end else begin
							stack[ptr[2:0]] <= push_val;
							ptr             <= ptr + 4'd1;
							pend            <= 1'b1;
						end
					end else if (advance && is_ret) begin
						if (excess != '0) begin
							excess <= excess - 4'd1;
						end else if (ptr != '0) begin
							cur_func <= stack[ptr_m1[2:0]];
							ptr      <= ptr_m1;
						end else begin
							state   <= prof_pkg::DONE;
							exe_end <= 1'b1;
						end
					end
				end
				default: begin
				end
			endcase
		end
	end

	// every RUN cycle counts, stalls included
	assign count_en = (state == prof_pkg::RUN);
	assign depth = ptr;

endmodule

// File: rtl/cycle_counter.sv
// bank of per-function saturating cycle counters with a host read port
`timescale 1ns/1ps

module cycle_counter (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            clear,
	input  logic                            count_en,
	input  logic [prof_pkg::FUNC_IDX_W-1:0] cur_func,
	input  logic [prof_pkg::FUNC_IDX_W-1:0] rd_idx,
	output logic [prof_pkg::CW-1:0]         rd_count
);

	logic [prof_pkg::CW-1:0] counts [prof_pkg::FUNC_COUNT];

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			for (int i = 0; i < prof_pkg::FUNC_COUNT; i++) begin
				counts[i] <= '0;
			end
		end else if (count_en) begin
			// hold at full scale instead of wrapping
			if (counts[cur_func] != '1) begin
				counts[cur_func] <= counts[cur_func] + 1'b1;
			end
		end
	end

	// combinational read port registered in the slave
	assign rd_count = counts[rd_idx];

endmodule

// File: rtl/leap_slave.sv
// memory-mapped slave for profiler control, status, function table and counters
`timescale 1ns/1ps

module leap_slave (
	input  logic                            clk,
	input  logic                            reset,
	input  leap_bus_pkg::bus_req_s          bus_req,
	output logic [31:0]                     readdata,
	output logic                            soft_reset,
	output logic                            arm,
	input  prof_pkg::tracker_state_e        state,
	input  logic                            overflow,
	input  logic [3:0]                      depth,
	output logic                            tbl_we,
	output logic [prof_pkg::FUNC_IDX_W-1:0] tbl_idx,
	output logic [prof_pkg::ADDR_W-1:0]     tbl_addr,
	output logic [prof_pkg::FUNC_IDX_W-1:0] tbl_rd_idx,
	input  logic [prof_pkg::ADDR_W-1:0]     tbl_rd_addr,
	output logic [prof_pkg::FUNC_IDX_W-1:0] cnt_rd_idx,
	input  logic [prof_pkg::CW-1:0]         rd_count
);

	localparam int RW = leap_bus_pkg::BUS_ADDR_W;
	localparam int IW = prof_pkg::FUNC_IDX_W;

	logic        wr;
	logic        rd;
	logic        sel_ctrl;
	logic        sel_status;
	logic        sel_func;
	logic        sel_count;
	logic [31:0] rd_mux;

	assign wr = bus_req.chipselect && bus_req.write;
	assign rd = bus_req.chipselect && bus_req.read;

	// table and counter regions are eight words each
	assign sel_ctrl = (bus_req.address == leap_bus_pkg::REG_CTRL);
	assign sel_status = (bus_req.address == leap_bus_pkg::REG_STATUS);
	assign sel_func = (bus_req.address[RW-1:IW] == leap_bus_pkg::REG_FUNC_BASE[RW-1:IW]);
	assign sel_count = (bus_req.address[RW-1:IW] == leap_bus_pkg::REG_COUNT_BASE[RW-1:IW]);

	assign tbl_we = wr && sel_func;
	assign tbl_idx = bus_req.address[IW-1:0];
	assign tbl_addr = bus_req.writedata;
	assign tbl_rd_idx = bus_req.address[IW-1:0];
	assign cnt_rd_idx = bus_req.address[IW-1:0];

	always_comb begin
		rd_mux = '0;
		if (sel_ctrl) begin
			rd_mux = {30'd0, arm, soft_reset};
		end else if (sel_status) begin
			rd_mux = {25'd0, depth, overflow, state};
		end else if (sel_func) begin
			rd_mux = tbl_rd_addr;
		end else if (sel_count) begin
			rd_mux = rd_count;
		end
	end

	// read data lands one cycle after the read and holds until the next one
	always_ff @(posedge clk) begin
		if (reset) begin
			readdata   <= '0;
			soft_reset <= 1'b0;
			arm        <= 1'b0;
		end else begin
			soft_reset <= wr && sel_ctrl && bus_req.writedata[0];
			if (wr && sel_ctrl) begin
				arm <= bus_req.writedata[1];
			end
			if (rd) begin
				readdata <= rd_mux;
			end
		end
	end

endmodule

// File: rtl/leap_profiler_top.sv
// function profiler top, takes the core trace and serves results to the host bus
`timescale 1ns/1ps

module leap_profiler_top (
	input  logic                   clk,
	input  logic                   reset,
	input  prof_pkg::trace_s       core_trace,
	input  leap_bus_pkg::bus_req_s bus_req,
	output logic [31:0]            readdata,
	output logic                   exe_start,
	output logic                   exe_end,
	output logic                   soft_reset
);

	prof_pkg::trace_s                aligned;
	logic                            advance;
	logic                            soft_clr;
	logic                            arm;
	logic [prof_pkg::ADDR_W-1:0]     lookup_target;
	logic [prof_pkg::ADDR_W-1:0]     entry_addr;
	logic [prof_pkg::FUNC_IDX_W-1:0] func_idx;
	logic [prof_pkg::FUNC_IDX_W-1:0] cur_func;
	logic                            count_en;
	prof_pkg::tracker_state_e        state;
	logic                            overflow;
	logic [3:0]                      depth;
	logic                            tbl_we;
	logic [prof_pkg::FUNC_IDX_W-1:0] tbl_idx;
	logic [prof_pkg::ADDR_W-1:0]     tbl_addr;
	logic [prof_pkg::FUNC_IDX_W-1:0] tbl_rd_idx;
	logic [prof_pkg::ADDR_W-1:0]     tbl_rd_addr;
	logic [prof_pkg::FUNC_IDX_W-1:0] cnt_rd_idx;
	logic [prof_pkg::CW-1:0]         rd_count;

	assign soft_clr = reset || soft_reset;

	trace_align u_align (
		.clk      (clk),
		.reset    (soft_clr),
		.trace_in (core_trace),
		.aligned  (aligned),
		.advance  (advance)
	);

	// table survives a soft reset
	func_lookup u_lookup (
		.clk         (clk),
		.reset       (reset),
		.tbl_we      (tbl_we),
		.tbl_idx     (tbl_idx),
		.tbl_addr    (tbl_addr),
		.target      (lookup_target),
		.entry_addr  (entry_addr),
		.func_idx    (func_idx),
		.tbl_rd_idx  (tbl_rd_idx),
		.tbl_rd_addr (tbl_rd_addr)
	);

	call_tracker u_tracker (
		.clk           (clk),
		.reset         (soft_clr),
		.arm           (arm),
		.aligned       (aligned),
		.advance       (advance),
		.entry_addr    (entry_addr),
		.func_idx      (func_idx),
		.lookup_target (lookup_target),
		.cur_func      (cur_func),
		.count_en      (count_en),
		.exe_start     (exe_start),
		.exe_end       (exe_end),
		.state         (state),
		.overflow      (overflow),
		.depth         (depth)
	);

	cycle_counter u_counter (
		.clk      (clk),
		.reset    (reset),
		.clear    (soft_reset),
		.count_en (count_en),
		.cur_func (cur_func),
		.rd_idx   (cnt_rd_idx),
		.rd_count (rd_count)
	);

	leap_slave u_slave (
		.clk         (clk),
		.reset       (reset),
		.bus_req     (bus_req),
		.readdata    (readdata),
		.soft_reset  (soft_reset),
		.arm         (arm),
		.state       (state),
		.overflow    (overflow),
		.depth       (depth),
		.tbl_we      (tbl_we),
		.tbl_idx     (tbl_idx),
		.tbl_addr    (tbl_addr),
		.tbl_rd_idx  (tbl_rd_idx),
		.tbl_rd_addr (tbl_rd_addr),
		.cnt_rd_idx  (cnt_rd_idx),
		.rd_count    (rd_count)
	);

endmodule

// File: tests/trace_table.svh
// trace rows and function table applied by the profiler testbench, included in its top module
`ifndef TRACE_TABLE_SVH
`define TRACE_TABLE_SVH

	// nested run with an unlisted callee, then a run that overflows the call stack
	localparam int N_ROWS = 41;
	localparam int A_FIRST = 0;
	localparam int A_LEN = 16;
	localparam int B_FIRST = 16;
	localparam int B_LEN = 25;
	localparam int MAX_HOLD = 20;

	// start addresses per slot, slot 0 stays empty for unlisted code
	localparam logic [31:0] FUNC_ADDR [8] = '{
		32'h0000_0000, 32'h0000_0100, 32'h0000_0200, 32'h0000_0300,
		32'h0000_0400, 32'h0000_0500, 32'h0000_0600, 32'h0000_0700
	};

	// columns: pc, instruction at that pc, base hold cycles, status check flag
	// jal target t encodes as 0C000000 | t/4, jr $ra as 03E00008
	localparam logic [31:0] ROW_PC [N_ROWS] = '{
		32'h0F8, 32'h0FC, 32'h100, 32'h104, 32'h200, 32'h204, 32'h300, 32'h304,
		32'h208, 32'h900, 32'h904, 32'h20C, 32'h108, 32'h10C, 32'hF00, 32'hF04,
		32'h0FC, 32'h100, 32'h104, 32'h200, 32'h300, 32'h400, 32'h500, 32'h600,
		32'h700, 32'h204, 32'h304, 32'h308, 32'h30C, 32'h310, 32'h314, 32'h318,
		32'h31C, 32'h320, 32'h324, 32'h328, 32'h32C, 32'h330, 32'h334, 32'h338,
		32'hF00
	};
	localparam logic [31:0] ROW_INS [N_ROWS] = '{
		32'h0, 32'h0, 32'h0, 32'h0C00_0080, 32'h0, 32'h0C00_00C0, 32'h0, 32'h03E0_0008,
		32'h0C00_0240, 32'h0, 32'h03E0_0008, 32'h03E0_0008, 32'h0, 32'h03E0_0008,
		32'h0, 32'h0,
		32'h0, 32'h0, 32'h0C00_0080, 32'h0C00_00C0, 32'h0C00_0100, 32'h0C00_0140,
		32'h0C00_0180, 32'h0C00_01C0, 32'h0C00_0080, 32'h0C00_00C0, 32'h0C00_0100,
		32'h0, 32'h0, 32'h0,
		32'h03E0_0008, 32'h03E0_0008, 32'h03E0_0008, 32'h03E0_0008, 32'h03E0_0008,
		32'h03E0_0008, 32'h03E0_0008, 32'h03E0_0008, 32'h03E0_0008, 32'h03E0_0008,
		32'h0
	};
	localparam int ROW_HOLD [N_ROWS] = '{
		2, 2, 3, 1, 4, 1, 5, 2, 1, 3, 1, 2, 6, 1, 2, 2,
		2, 2, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, MAX_HOLD,
		2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 3
	};
	// status is read in the middle of a row flagged here
	localparam bit ROW_CHK [N_ROWS] = '{
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
		0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0
	};

`endif

// File: tests/tb_leap_profiler.sv
// testbench for the profiler top that replays trace tables and checks counters against a model
`timescale 1ns/1ps

module tb_leap_profiler;

	`include "trace_table.svh"

	localparam int WATCHDOG_NS = (2 * N_ROWS * (MAX_HOLD + 3) + 1000) * 100;

	logic                   clk;
	logic                   reset;
	prof_pkg::trace_s       core_trace;
	leap_bus_pkg::bus_req_s bus_req;
	logic [31:0]            readdata;
	logic                   exe_start;
	logic                   exe_end;
	logic                   soft_reset;

	logic        armed;
	logic        model_clr;
	logic [31:0] lcg_state;
	int          start_seen;
	int          end_seen;

	// model of the profiler stepped on every rising edge
	logic [31:0] m_last_pc;
	logic [31:0] pc_prev2;
	logic [31:0] ins_prev;
	logic        val_prev;
	logic        m_adv;
	logic [31:0] ev_pc;
	logic [31:0] ev_ins;
	logic        ev_val;
	int          m_state;
	int          m_cur;
	int          m_stack [8];
	int          m_depth;
	int          m_excess;
	logic        m_ovf;
	logic        m_pend;
	int          m_pend_idx;
	logic [31:0] m_count [8];

	leap_profiler_top UUT (
		.clk        (clk),
		.reset      (reset),
		.core_trace (core_trace),
		.bus_req    (bus_req),
		.readdata   (readdata),
		.exe_start  (exe_start),
		.exe_end    (exe_end),
		.soft_reset (soft_reset)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// lowest listed slot whose start address equals the target, else slot 0
	function automatic int slot_of(input logic [31:0] target);
		int idx;
		idx = 0;
		for (int i = 7; i > 0; i--) begin
			if (FUNC_ADDR[i] == target) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	function automatic logic [31:0] model_status();
		return {25'd0, 4'(m_depth), m_ovf, 2'(m_state)};
	endfunction

	task automatic apply_event(input logic [31:0] pc, input logic [31:0] ins, input logic val);
		logic is_call;
		logic is_return;
		logic [31:0] target;
		is_call = val && (ins[31:26] == 6'h03);
		is_return = (ins[31:26] == 6'h00) && (ins[5:0] == 6'h08) && (ins[25:21] == 5'd31);
		target = {pc[31:28], ins[25:0], 2'b00};
		if (m_state == 0) begin
			if (armed && (pc == FUNC_ADDR[1])) begin
				m_state = 1;
				m_cur = 1;
			end
		end else if (m_state == 1) begin
			if (is_call) begin
				if (m_depth == 8) begin
					m_ovf = 1'b1;
					if (m_excess < 15) begin
						m_excess++;
					end
				end else begin
					m_stack[m_depth] = m_cur;
					m_depth++;
					m_pend = 1'b1;
					m_pend_idx = slot_of(target);
				end
			end else if (is_return) begin
				if (m_excess > 0) begin
					m_excess--;
				end else if (m_depth > 0) begin
					m_depth--;
					m_cur = m_stack[m_depth];
				end else begin
					m_state = 2;
				end
			end
		end
	endtask

	always @(posedge clk) begin
		if (reset || model_clr) begin
			m_last_pc = '0;
			pc_prev2 = '0;
			ins_prev = '0;
			val_prev = 1'b0;
			m_adv = 1'b0;
			m_state = 0;
			m_cur = 0;
			m_depth = 0;
			m_excess = 0;
			m_ovf = 1'b0;
			m_pend = 1'b0;
			for (int i = 0; i < 8; i++) begin
				m_count[i] = '0;
			end
		end else begin
			// every running cycle counts against the function in force before the edge
			if (m_state == 1) begin
				m_count[m_cur] = m_count[m_cur] + 32'd1;
			end
			if (m_pend) begin
				m_cur = m_pend_idx;
				m_pend = 1'b0;
			end
			if (m_adv) begin
				apply_event(ev_pc, ev_ins, ev_val);
			end
			m_adv = 1'b0;
			// pc is seen three changes late and the fetched word two changes late
			if (core_trace.pc != m_last_pc) begin
				ev_pc = pc_prev2;
				ev_ins = ins_prev;
				ev_val = val_prev;
				m_adv = 1'b1;
				pc_prev2 = m_last_pc;
				ins_prev = core_trace.instr;
				val_prev = core_trace.valid;
			end
			m_last_pc = core_trace.pc;
		end
	end

	// pulse counters sampled away from the rising edge
	always @(negedge clk) begin
		if (reset) begin
			start_seen <= 0;
			end_seen <= 0;
		end else begin
			if (exe_start) begin
				start_seen <= start_seen + 1;
			end
			if (exe_end) begin
				end_seen <= end_seen + 1;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		bus_req = {1'b1, 1'b0, 1'b1, addr, data};
		@(negedge clk);
		bus_req = '0;
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge clk);
		bus_req = {1'b1, 1'b1, 1'b0, addr, 32'd0};
		@(negedge clk);
		bus_req = '0;
		data = readdata;
	endtask

	task automatic check_counters(input string name);
		logic [31:0] value;
		for (int f = 0; f < 8; f++) begin
			bus_read(leap_bus_pkg::REG_COUNT_BASE + 8'(f), value);
			check_value($sformatf("%s count %0d", name, f), m_count[f], value);
		end
		bus_read(leap_bus_pkg::REG_STATUS, value);
		check_value({name, " status"}, model_status(), value);
	endtask

	task automatic check_table(input string name);
		logic [31:0] value;
		for (int i = 0; i < 8; i++) begin
			bus_read(leap_bus_pkg::REG_FUNC_BASE + 8'(i), value);
			check_value($sformatf("%s slot %0d", name, i), FUNC_ADDR[i], value);
		end
	endtask

	task automatic soft_clear();
		// keep arm set while pulsing soft reset
		bus_write(leap_bus_pkg::REG_CTRL, 32'd3);
		// soft reset is high for the one cycle after the write
		check_value("soft reset pulse", 32'd1, 32'(soft_reset));
		model_clr = 1'b1;
		@(negedge clk);
		model_clr = 1'b0;
		check_value("soft reset release", 32'd0, 32'(soft_reset));
		repeat (3) @(negedge clk);
	endtask

	task automatic run_stream(input string name, input int first, input int len);
		logic [31:0] prev_ins;
		logic [31:0] value;
		int hold;
		int start_base;
		int end_base;
		prev_ins = '0;
		start_base = start_seen;
		end_base = end_seen;
		for (int i = first; i < first + len; i++) begin
			lcg_state = lcg_next(lcg_state);
			hold = ROW_HOLD[i] + int'(lcg_state[17:16]);
			@(negedge clk);
			// the core reports the fetched word one pc behind
			core_trace = {ROW_PC[i], prev_ins, 1'b1};
			prev_ins = ROW_INS[i];
			if (ROW_CHK[i]) begin
				bus_read(leap_bus_pkg::REG_STATUS, value);
				check_value({name, " mid-run status"}, model_status(), value);
				repeat (hold - 3) @(negedge clk);
			end else begin
				repeat (hold - 1) @(negedge clk);
			end
		end
		@(negedge clk);
		core_trace = {32'd0, prev_ins, 1'b0};
		while (end_seen == end_base) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		check_value({name, " exe_start pulses"}, 32'd1, 32'(start_seen - start_base));
		check_value({name, " exe_end pulses"}, 32'd1, 32'(end_seen - end_base));
		check_counters(name);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		reset = 1'b1;
		core_trace = '0;
		bus_req = '0;
		armed = 1'b0;
		model_clr = 1'b0;
		lcg_state = 32'he334_162b;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);

		// idle after reset
		check_counters("after reset");
		check_value("idle exe_start", 32'd0, 32'(start_seen));
		check_value("idle exe_end", 32'd0, 32'(end_seen));
		check_value("idle soft_reset", 32'd0, 32'(soft_reset));

		for (int i = 0; i < 8; i++) begin
			bus_write(leap_bus_pkg::REG_FUNC_BASE + 8'(i), FUNC_ADDR[i]);
		end
		check_table("table readback");

		bus_write(leap_bus_pkg::REG_CTRL, 32'd2);
		armed = 1'b1;
		run_stream("nested run", A_FIRST, A_LEN);

		soft_clear();
		check_counters("soft reset");
		check_table("table after soft reset");
		run_stream("second run", A_FIRST, A_LEN);

		soft_clear();
		run_stream("overflow run", B_FIRST, B_LEN);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: leap_profiler.f
+incdir+tests
rtl/prof_pkg.sv
rtl/leap_bus_pkg.sv
rtl/trace_align.sv
rtl/func_lookup.sv
rtl/call_tracker.sv
rtl/cycle_counter.sv
rtl/leap_slave.sv
rtl/leap_profiler_top.sv
tests/tb_leap_profiler.sv

// File: run_sim.sh
#!/bin/sh
# build and run the profiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_leap_profiler \
	-f leap_profiler.f -o sim_leap_profiler
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_leap_profiler > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation returned status $run_status"
	exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
